//--- Bender.yml
package:
  name: l2_cache

sources:
  - source/cache_pkg.sv
  - source/cache_tag_array.sv
  - source/cache_data_array.sv
  - source/plru_tree.sv
  - source/cache_control.sv
  - source/l2_cache.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/l2_cache_tb.sv

//--- bench/l2_cache_tb.sv
module l2_cache_tb;

    localparam int SET_BITS = 4;
    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int TAG_BITS = cache_pkg::ADDR_WIDTH - SET_BITS;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_RANDOM = 400;
    localparam int NUM_REQS = NUM_RANDOM + 10;
    localparam int MISS_BOUND = 200;   // cycles for write-back plus fetch under back-pressure

    logic             clk = 1'b0;
    logic             reset;
    logic             cpu_req_valid;
    logic             cpu_req_ready;
    logic             cpu_req_write;
    cache_pkg::addr_t cpu_req_addr;
    cache_pkg::data_t cpu_req_wdata;
    logic             cpu_resp_valid;
    cache_pkg::data_t cpu_rdata;
    logic             mem_req_valid;
    logic             mem_req_ready;
    logic             mem_req_write;
    cache_pkg::addr_t mem_req_addr;
    cache_pkg::data_t mem_req_wdata;
    logic             mem_resp_valid;
    cache_pkg::data_t mem_rdata;

    // reference copy of the cache and the backing memory
    logic [TAG_BITS-1:0]  ref_tag   [NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::data_t     ref_data  [NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::way_mask_t ref_valid [NUM_SETS];
    cache_pkg::way_mask_t ref_dirty [NUM_SETS];
    cache_pkg::plru_t     ref_tree  [NUM_SETS];
    cache_pkg::data_t     ref_mem   [1 << cache_pkg::ADDR_WIDTH];

    cache_pkg::addr_t seen_rd_addr [$];
    cache_pkg::addr_t seen_wr_addr [$];
    cache_pkg::data_t seen_wr_data [$];

    logic [31:0]      rng;
    cache_pkg::addr_t evicted_addr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    l2_cache #(.SET_BITS(SET_BITS)) dut0 (
        .clk, .reset,
        .cpu_req_valid, .cpu_req_ready, .cpu_req_write, .cpu_req_addr,
        .cpu_req_wdata, .cpu_resp_valid, .cpu_rdata,
        .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr,
        .mem_req_wdata, .mem_resp_valid, .mem_rdata
    );

    mem_model #(.SEED(32'd74969)) mem0 (
        .clk, .reset,
        .req_valid(mem_req_valid), .req_ready(mem_req_ready), .req_write(mem_req_write),
        .req_addr(mem_req_addr), .req_wdata(mem_req_wdata),
        .resp_valid(mem_resp_valid), .rdata(mem_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cache_pkg::data_t mem_fill_word(input cache_pkg::addr_t a);
        return {a ^ 16'hc3a5, ~a};
    endfunction

    function automatic cache_pkg::addr_t make_addr(input int tag, input int set);
        return cache_pkg::addr_t'({TAG_BITS'(tag), SET_BITS'(set)});
    endfunction

    // 0 at any node means the lower side
    function automatic int tree_victim(input cache_pkg::plru_t t);
        int half;
        int pair;
        half = t[0];
        pair = 2 * half + (half ? t[2] : t[1]);
        return 2 * pair + t[3 + pair];
    endfunction

    function automatic cache_pkg::plru_t tree_touch(input cache_pkg::plru_t t, input int w);
        cache_pkg::plru_t r;
        r = t;
        r[0] = (w < 4);
        r[1 + w / 4] = ((w / 2) % 2 == 0);
        r[3 + w / 2] = (w % 2 == 0);
        return r;
    endfunction

    task automatic fail_with(input string what);
        $display("error at %0t: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // called on a rising edge, returns on the response edge
    task automatic run_request(input logic write, input cache_pkg::addr_t addr,
                               input cache_pkg::data_t wdata);
        int set;
        int way;
        int cycles;
        logic [TAG_BITS-1:0] tag;
        logic hit;
        logic expect_wb;
        cache_pkg::addr_t wb_addr;
        cache_pkg::data_t wb_data;
        cache_pkg::data_t got_rdata;

        set = addr % NUM_SETS;
        tag = addr >> SET_BITS;
        hit = 1'b0;
        way = 0;
        expect_wb = 1'b0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = tree_victim(ref_tree[set]);
            wb_addr = make_addr(ref_tag[set][way], set);
            wb_data = ref_data[set][way];
            expect_wb = ref_valid[set][way] && ref_dirty[set][way];
            if (ref_valid[set][way]) evicted_addr = wb_addr;
        end

        seen_rd_addr.delete();
        seen_wr_addr.delete();
        seen_wr_data.delete();

        cpu_req_valid <= 1'b1;
        cpu_req_write <= write;
        cpu_req_addr <= addr;
        cpu_req_wdata <= wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cpu_req_ready && cycles < MISS_BOUND);
        if (!cpu_req_ready) fail_with("request was never accepted");
        cpu_req_valid <= 1'b0;

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            got_rdata = cpu_rdata;
        end while (!cpu_resp_valid && cycles < MISS_BOUND);
        if (!cpu_resp_valid) fail_with("no cpu response within the miss bound");

        if (hit) begin
            check_value("hit latency", cycles, 1);
            check_value("mem reads on hit", seen_rd_addr.size(), 0);
            check_value("mem writes on hit", seen_wr_addr.size(), 0);
        end else begin
            check_value("mem reads on miss", seen_rd_addr.size(), 1);
            check_value("mem_req_addr fetch", seen_rd_addr[0], addr);
            check_value("mem writes on miss", seen_wr_addr.size(), expect_wb);
            if (expect_wb) begin
                check_value("mem_req_addr write-back", seen_wr_addr[0], wb_addr);
                check_value("mem_req_wdata", seen_wr_data[0], wb_data);
            end
            if (expect_wb) ref_mem[wb_addr] = wb_data;
            ref_tag[set][way] = tag;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = 1'b0;
            ref_data[set][way] = ref_mem[addr];
        end
        if (!write) check_value("cpu_rdata", got_rdata, ref_data[set][way]);
        if (write) begin
            ref_data[set][way] = wdata;
            ref_dirty[set][way] = 1'b1;
        end
        ref_tree[set] = tree_touch(ref_tree[set], way);
    endtask

    // accepted memory requests of the current cpu request
    always @(posedge clk) begin
        if (!reset && mem_req_valid && mem_req_ready) begin
            if (mem_req_write) begin
                seen_wr_addr.push_back(mem_req_addr);
                seen_wr_data.push_back(mem_req_wdata);
            end else begin
                seen_rd_addr.push_back(mem_req_addr);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
            && $stable(mem_req_addr) && $stable(mem_req_wdata))
        else fail_with("memory request changed before it was accepted");

    assert property (@(posedge clk) disable iff (reset)
        !cpu_req_ready && !cpu_resp_valid |=> !cpu_req_ready)
        else fail_with("cpu_req_ready rose before the response");

    assert property (@(posedge clk) disable iff (reset)
        cpu_resp_valid |=> !cpu_resp_valid && cpu_req_ready)
        else fail_with("cpu_resp_valid was not a single pulse followed by idle");

    initial begin
        #((NUM_REQS * MISS_BOUND + 20) * CLK_PERIOD);
        fail_with("watchdog expired before all requests completed");
    end

    initial begin
        reset <= 1'b1;
        cpu_req_valid <= 1'b0;
        cpu_req_write <= 1'b0;
        cpu_req_addr <= '0;
        cpu_req_wdata <= '0;
        rng = 32'd74969;
        evicted_addr = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s] = '0;
            ref_dirty[s] = '0;
            ref_tree[s] = '0;
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                ref_tag[s][w] = '0;
                ref_data[s][w] = '0;
            end
        end
        for (int a = 0; a < (1 << cache_pkg::ADDR_WIDTH); a++) begin
            ref_mem[a] = mem_fill_word(cache_pkg::addr_t'(a));
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("cpu_resp_valid", cpu_resp_valid, 0);
        check_value("mem_req_valid", mem_req_valid, 0);
        check_value("cpu_req_ready", cpu_req_ready, 1);

        // nine tags into set 5, the first one dirty
        run_request(1'b1, make_addr(0, 5), 32'hd00d_0005);
        for (int t = 1; t <= 8; t++) begin
            run_request(1'b0, make_addr(t, 5), '0);
        end
        run_request(1'b0, evicted_addr, '0);

        // a pool of twelve tags crowding sets 1 to 3
        for (int i = 0; i < NUM_RANDOM; i++) begin
            int set;
            int tag;
            logic write;
            rng = xorshift32(rng);
            set = 1 + rng[1:0] % 3;
            tag = rng[7:4] % 12;
            write = (rng[10:8] < 3);
            rng = xorshift32(rng);
            run_request(write, make_addr(tag, set), rng);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- bench/mem_model.sv
module mem_model #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             req_valid,
    output logic             req_ready,
    input  logic             req_write,
    input  cache_pkg::addr_t req_addr,
    input  cache_pkg::data_t req_wdata,
    output logic             resp_valid,
    output cache_pkg::data_t rdata
);

    cache_pkg::data_t storage [1 << cache_pkg::ADDR_WIDTH];

    logic [31:0]      rng;
    logic             busy;
    logic [1:0]       delay;          // cycles left before the response
    logic             pending_write;
    cache_pkg::addr_t pending_addr;
    cache_pkg::data_t pending_wdata;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every word tells its own address
    function automatic cache_pkg::data_t fill_word(input cache_pkg::addr_t a);
        return {a ^ 16'hc3a5, ~a};
    endfunction

    initial begin
        rng = SEED;
        busy = 1'b0;
        req_ready = 1'b0;
        resp_valid = 1'b0;
        rdata = '0;
        for (int a = 0; a < (1 << cache_pkg::ADDR_WIDTH); a++) begin
            storage[a] = fill_word(cache_pkg::addr_t'(a));
        end
    end

    always @(posedge clk) begin
        rng = xorshift32(rng);
        resp_valid <= 1'b0;
        if (reset) begin
            req_ready <= 1'b0;
            busy <= 1'b0;
        end else if (busy) begin
            if (delay == 0) begin
                resp_valid <= 1'b1;
                busy <= 1'b0;
                if (pending_write) begin
                    storage[pending_addr] <= pending_wdata;
                end else begin
                    rdata <= storage[pending_addr];
                end
            end else begin
                delay <= delay - 2'd1;
            end
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
            delay <= rng[1:0];
            pending_write <= req_write;
            pending_addr <= req_addr;
            pending_wdata <= req_wdata;
            req_ready <= 1'b0;      // one request at a time
        end else begin
            req_ready <= rng[2] | rng[3];   // ready about three cycles in four
        end
    end

endmodule

//--- flist.f
source/cache_pkg.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/plru_tree.sv
source/cache_control.sv
source/l2_cache.sv
bench/mem_model.sv
bench/l2_cache_tb.sv

//--- source/cache_control.sv
module cache_control #(
    parameter int SET_BITS = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,

    input  logic                                         cpu_req_valid,
    output logic                                         cpu_req_ready,
    input  logic                                         cpu_req_write,
    input  cache_pkg::addr_t                             cpu_req_addr,
    input  cache_pkg::data_t                             cpu_req_wdata,
    output logic                                         cpu_resp_valid,
    output cache_pkg::data_t                             cpu_rdata,

    output logic [SET_BITS-1:0]                          lookup_set,
    output logic [cache_pkg::ADDR_WIDTH-SET_BITS-1:0]    lookup_tag,
    input  cache_pkg::way_mask_t                         hit_mask,
    input  cache_pkg::way_idx_t                          victim_way,
    input  logic                                         victim_valid,
    input  logic                                         victim_dirty,
    input  logic [cache_pkg::ADDR_WIDTH-SET_BITS-1:0]    victim_tag,
    output logic                                         hit_write,
    output logic                                         fill,
    output logic                                         access,
    output cache_pkg::way_idx_t                          access_way,
    output cache_pkg::way_idx_t                          sel_way,
    output cache_pkg::data_t                             store_wdata,
    input  cache_pkg::data_t                             rdata,

    output logic                                         mem_req_valid,
    input  logic                                         mem_req_ready,
    output logic                                         mem_req_write,
    output cache_pkg::addr_t                             mem_req_addr,
    output cache_pkg::data_t                             mem_req_wdata,
    input  logic                                         mem_resp_valid,
    input  cache_pkg::data_t                             mem_rdata
);

    cache_pkg::ctrl_state_t state, next_state;

    // latched request
    logic             req_write;
    cache_pkg::addr_t req_addr;
    cache_pkg::data_t req_wdata;
    cache_pkg::data_t fill_data;   // word from the fetch response

    logic                hit;
    cache_pkg::way_idx_t hit_way;
    logic                lookup_hit;

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_write <= cpu_req_write;
            req_addr  <= cpu_req_addr;
            req_wdata <= cpu_req_wdata;
        end
        if (state == cache_pkg::FETCH_WAIT && mem_resp_valid) begin
            fill_data <= mem_rdata;
        end
    end

    assign lookup_set = req_addr[SET_BITS-1:0];
    assign lookup_tag = req_addr[cache_pkg::ADDR_WIDTH-1:SET_BITS];

    // mask is one-hot on a hit
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (hit_mask[w]) begin
                hit_way = cache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit        = |hit_mask;
    assign lookup_hit = (state == cache_pkg::LOOKUP) && hit;

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE: begin
                if (cpu_req_valid) next_state = cache_pkg::LOOKUP;
            end
            cache_pkg::LOOKUP: begin
                if (hit) begin
                    next_state = cache_pkg::IDLE;
                end else if (victim_valid && victim_dirty) begin
                    next_state = cache_pkg::WRITE_BACK_REQ;
                end else begin
                    next_state = cache_pkg::FETCH_REQ;
                end
            end
            cache_pkg::WRITE_BACK_REQ: begin
                if (mem_req_ready) next_state = cache_pkg::WRITE_BACK_WAIT;
            end
            cache_pkg::WRITE_BACK_WAIT: begin
                if (mem_resp_valid) next_state = cache_pkg::FETCH_REQ;
            end
            cache_pkg::FETCH_REQ: begin
                if (mem_req_ready) next_state = cache_pkg::FETCH_WAIT;
            end
            cache_pkg::FETCH_WAIT: begin
                if (mem_resp_valid) next_state = cache_pkg::FILL;
            end
            cache_pkg::FILL: begin
                next_state = cache_pkg::IDLE;
            end
            default: next_state = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign cpu_req_ready  = (state == cache_pkg::IDLE);
    assign cpu_resp_valid = lookup_hit || (state == cache_pkg::FILL);
    assign cpu_rdata      = (state == cache_pkg::FILL) ? fill_data : rdata;

    // write miss stores the cpu word over the fetched one
    assign fill        = (state == cache_pkg::FILL);
    assign hit_write   = (lookup_hit || fill) && req_write;
    assign access      = lookup_hit || fill;
    assign store_wdata = hit_write ? req_wdata : fill_data;

    assign sel_way    = (state == cache_pkg::LOOKUP) ? hit_way : victim_way;
    assign access_way = sel_way;

    assign mem_req_valid = (state == cache_pkg::WRITE_BACK_REQ) ||
                           (state == cache_pkg::FETCH_REQ);
    assign mem_req_write = (state == cache_pkg::WRITE_BACK_REQ);
    assign mem_req_addr  = mem_req_write ? {victim_tag, lookup_set} : req_addr;
    assign mem_req_wdata = rdata;   // victim word, sel_way follows the victim

endmodule

//--- source/cache_data_array.sv
module cache_data_array #(
    parameter int SET_BITS = 4
) (
    input  logic                  clk,
    input  logic [SET_BITS-1:0]   lookup_set,
    input  cache_pkg::way_idx_t   sel_way,
    input  logic                  hit_write,
    input  logic                  fill,
    input  cache_pkg::way_idx_t   access_way,
    input  cache_pkg::data_t      store_wdata,
    output cache_pkg::data_t      rdata
);

    localparam int NUM_SETS = 1 << SET_BITS;

    cache_pkg::data_t words [NUM_SETS][cache_pkg::NUM_WAYS];

    always_ff @(posedge clk) begin
        if (hit_write || fill) begin
            words[lookup_set][access_way] <= store_wdata;
        end
    end

    // hit way on lookup, victim way on write-back
    assign rdata = words[lookup_set][sel_way];

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

    // word addresses on both sides
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    // fixed by the 7-node tree
    localparam int NUM_WAYS = 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;

    // hit, valid and dirty vectors
    typedef logic [NUM_WAYS-1:0] way_mask_t;

    // bit 0 root, bits 1-2 middle nodes, bits 3-6 leaves
    // a node at 0 points toward the lower half, pair or way
    typedef logic [NUM_WAYS-2:0] plru_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK_REQ,
        WRITE_BACK_WAIT,
        FETCH_REQ,
        FETCH_WAIT,
        FILL
    } ctrl_state_t;

endpackage

//--- source/cache_tag_array.sv
module cache_tag_array #(
    parameter int SET_BITS = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [SET_BITS-1:0]                          lookup_set,
    input  logic [cache_pkg::ADDR_WIDTH-SET_BITS-1:0]    lookup_tag,
    input  cache_pkg::way_idx_t                          victim_way,
    input  logic                                         hit_write,
    input  logic                                         fill,
    input  cache_pkg::way_idx_t                          access_way,
    output cache_pkg::way_mask_t                         hit_mask,
    output logic                                         victim_valid,
    output logic                                         victim_dirty,
    output logic [cache_pkg::ADDR_WIDTH-SET_BITS-1:0]    victim_tag
);

    localparam int TAG_BITS = cache_pkg::ADDR_WIDTH - SET_BITS;
    localparam int NUM_SETS = 1 << SET_BITS;

    logic [TAG_BITS-1:0] tags [NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::way_mask_t valid [NUM_SETS];
    cache_pkg::way_mask_t dirty [NUM_SETS];

    // all eight ways compared at once
    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            hit_mask[w] = valid[lookup_set][w] && (tags[lookup_set][w] == lookup_tag);
        end
    end

    assign victim_valid = valid[lookup_set][victim_way];
    assign victim_dirty = dirty[lookup_set][victim_way];
    assign victim_tag   = tags[lookup_set][victim_way];

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[lookup_set][access_way] <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (fill) begin
                valid[lookup_set][access_way] <= 1'b1;
                dirty[lookup_set][access_way] <= 1'b0;
            end
            // a write miss fills and writes in the same cycle, so dirty wins
            if (hit_write) begin
                dirty[lookup_set][access_way] <= 1'b1;
            end
        end
    end

endmodule

//--- source/l2_cache.sv
module l2_cache #(
    parameter int SET_BITS = 4
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             cpu_req_valid,
    output logic             cpu_req_ready,
    input  logic             cpu_req_write,
    input  cache_pkg::addr_t cpu_req_addr,
    input  cache_pkg::data_t cpu_req_wdata,
    output logic             cpu_resp_valid,
    output cache_pkg::data_t cpu_rdata,

    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output logic             mem_req_write,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::data_t mem_req_wdata,
    input  logic             mem_resp_valid,
    input  cache_pkg::data_t mem_rdata
);

    localparam int TAG_BITS = cache_pkg::ADDR_WIDTH - SET_BITS;

    logic [SET_BITS-1:0]  lookup_set;
    logic [TAG_BITS-1:0]  lookup_tag;
    logic [TAG_BITS-1:0]  victim_tag;
    cache_pkg::way_mask_t hit_mask;
    cache_pkg::way_idx_t  victim_way;
    cache_pkg::way_idx_t  access_way;
    cache_pkg::way_idx_t  sel_way;
    logic                 victim_valid;
    logic                 victim_dirty;
    logic                 hit_write;
    logic                 fill;
    logic                 access;
    cache_pkg::data_t     store_wdata;
    cache_pkg::data_t     rdata;

    cache_control #(.SET_BITS(SET_BITS)) control0 (
        .clk, .reset,
        .cpu_req_valid, .cpu_req_ready, .cpu_req_write, .cpu_req_addr,
        .cpu_req_wdata, .cpu_resp_valid, .cpu_rdata,
        .lookup_set, .lookup_tag, .hit_mask, .victim_way, .victim_valid,
        .victim_dirty, .victim_tag, .hit_write, .fill, .access, .access_way,
        .sel_way, .store_wdata, .rdata,
        .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr,
        .mem_req_wdata, .mem_resp_valid, .mem_rdata
    );

    cache_tag_array #(.SET_BITS(SET_BITS)) tags0 (
        .clk, .reset, .lookup_set, .lookup_tag, .victim_way, .hit_write,
        .fill, .access_way, .hit_mask, .victim_valid, .victim_dirty, .victim_tag
    );

    cache_data_array #(.SET_BITS(SET_BITS)) data0 (
        .clk, .lookup_set, .sel_way, .hit_write, .fill, .access_way,
        .store_wdata, .rdata
    );

    plru_tree #(.SET_BITS(SET_BITS)) plru0 (
        .clk, .reset, .lookup_set, .access, .access_way, .victim_way
    );

endmodule

//--- source/plru_tree.sv
module plru_tree #(
    parameter int SET_BITS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [SET_BITS-1:0]   lookup_set,
    input  logic                  access,
    input  cache_pkg::way_idx_t   access_way,
    output cache_pkg::way_idx_t   victim_way
);

    localparam int NUM_SETS = 1 << SET_BITS;

    cache_pkg::plru_t trees [NUM_SETS];
    cache_pkg::plru_t cur_tree;
    cache_pkg::plru_t new_tree;
    logic [1:0] pair;

    assign cur_tree = trees[lookup_set];

    // root picks the half, middle node the pair, leaf the way
    always_comb begin
        if (cur_tree[0]) begin
            pair = {1'b1, cur_tree[2]};
        end else begin
            pair = {1'b0, cur_tree[1]};
        end
        victim_way = {pair, cur_tree[3 + pair]};
    end

    // path nodes point away from the accessed way
    always_comb begin
        new_tree = cur_tree;
        new_tree[0] = ~access_way[2];
        new_tree[1 + access_way[2]] = ~access_way[1];
        new_tree[3 + access_way[2:1]] = ~access_way[0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                trees[s] <= '0;
            end
        end else if (access) begin
            trees[lookup_set] <= new_tree;
        end
    end

endmodule
